/* dv/escape_stim.txt */
# test <name> | c <code hex> <length> | rep <code hex> <length> <count>
# rnd <count> draws seeded random codes | flush [expected frame bytes]
test plain_words
c 1234 16
c 5678 16
c 9abc 16
c def0 16
flush 10
test plain_pad
c 0123 16
c 045 12
c 5 3
flush 6
test ff_lanes
c ff11 16
c 2233 16
c 44ff 16
c 5566 16
c 7788 16
c ff99 16
c aabb 16
c ccff 16
c ffff 16
c 0102 16
flush 28
test pad_to_ff
c abcd 16
c f 4
flush 6
test pad_short
c 3 2
flush 4
test tail_spill
c 1234 16
c 7 0
c 56 7
flush 5
test ones_burst
rep ffff 16 64
flush 258
test random_mix
rnd 200
flush
test one_byte
c a5 8
flush 3
test empty_frame
flush 2

/* dv/jpeg_entropy_tail_tb.sv */
// testbench for the entropy coder tail, checks packed, stuffed and terminated frames
`timescale 1ns/10ps
`default_nettype none

module jpeg_entropy_tail_tb;
    import jpeg_tail_pkg::*;

    logic       xclk;
    logic       rst;
    code_t      code;
    code_len_t  code_len;
    logic       code_stb;
    logic       flush_in;
    word_t      out_data;
    byte_cnt_t  out_bytes;
    logic       out_stb;
    logic       out_done;
    frame_cnt_t frame_bytes;

    code_t      code_q[$];          // codes of all tests, file order
    code_len_t  len_q[$];
    string      name_q[$];          // one entry per test
    int         first_q[$];         // index of the test's first code
    int         count_q[$];
    int         want_q[$];          // frame bytes from the file, -1 if not given
    logic [7:0] exp_q[$];           // reference bytes, running test
    logic [7:0] got_q[$];           // bytes seen on out_data
    string      cur_name = "reset";
    logic       frame_done;
    int         done_bytes;         // frame_bytes at out_done
    int         test_errs;
    int         failed;
    int         load_errs;
    int         seed;
    int         cycle_cnt;
    int         cycle_limit;
    int         mon_n;
    int         mon_k;

    tb_clk_gen clk_gen_inst (.xclk(xclk), .rst(rst));

    jpeg_entropy_tail jpeg_entropy_tail_inst (
        .xclk     (xclk),     .rst       (rst),
        .code     (code),     .code_len  (code_len),
        .code_stb (code_stb), .flush_in  (flush_in),
        .out_data (out_data), .out_bytes (out_bytes),
        .out_stb  (out_stb),  .out_done  (out_done),
        .frame_bytes (frame_bytes)
    );

    task automatic load_stimulus();
        int    fd;
        int    n;
        int    cv;
        int    lv;
        int    rv;
        string line;
        string kw;
        string nm;
        fd = $fopen("dv/escape_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/escape_stim.txt");
            load_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%s", kw);
            if (n < 1 || kw.substr(0, 0) == "#") continue;  // blank or comment
            if (kw == "test") begin
                void'($sscanf(line, "%s %s", kw, nm));
                name_q.push_back(nm);
                first_q.push_back(code_q.size());
            end else if (kw == "c" || kw == "rep") begin
                n = $sscanf(line, "%s %h %d %d", kw, cv, lv, rv);
                if (n < 4) rv = 1;                 // plain code line
                repeat (rv) begin
                    code_q.push_back(code_t'(cv));
                    len_q.push_back(code_len_t'(lv));
                end
            end else if (kw == "rnd") begin
                void'($sscanf(line, "%s %d", kw, rv));
                repeat (rv) begin
                    lv = ($random(seed) & 15) + 1; // lengths 1..16
                    code_q.push_back(code_t'($random(seed)));  // upper bits are junk
                    len_q.push_back(code_len_t'(lv));
                end
            end else if (kw == "flush") begin
                n = $sscanf(line, "%s %d", kw, rv);
                count_q.push_back(code_q.size() - first_q[$]);
                want_q.push_back(n == 2 ? rv : -1);
            end else begin
                $display("unreadable line in the stimulus file: %s", line);
                load_errs++;
            end
        end
        $fclose(fd);
        if (name_q.size() == 0 || name_q.size() != count_q.size()) begin
            $display("stimulus file has a test without its flush line");
            load_errs++;
        end
    endtask

    task automatic push_escaped(input logic [7:0] b);
        exp_q.push_back(b);
        if (b == 8'hff) exp_q.push_back(8'h00);  // byte stuffing
    endtask

    // reference stream: bits msb first, ones pad, stuffing, eoi
    task automatic build_expected(input int t);
        int         i;
        int         b;
        int         nb;
        logic [7:0] acc;
        exp_q.delete();
        acc = '0;
        nb  = 0;
        for (i = first_q[t]; i < first_q[t] + count_q[t]; i++) begin
            for (b = int'(len_q[i]) - 1; b >= 0; b--) begin
                acc = {acc[6:0], code_q[i][b]};
                nb++;
                if (nb == 8) begin
                    push_escaped(acc);
                    nb = 0;
                end
            end
        end
        if (nb != 0) begin
            while (nb < 8) begin
                acc = {acc[6:0], 1'b1};  // pad with ones
                nb++;
            end
            push_escaped(acc);
        end
        exp_q.push_back(8'hff);
        exp_q.push_back(8'hd9);
    endtask

    task automatic drive_frame(input int t);
        int i;
        for (i = first_q[t]; i < first_q[t] + count_q[t]; i++) begin
            @(posedge xclk);
            code     <= code_q[i];
            code_len <= len_q[i];
            code_stb <= 1'b1;            // back to back, worst case rate
        end
        @(posedge xclk);
        code_stb <= 1'b0;
        flush_in <= 1'b1;                // pulse right after the last code
        @(posedge xclk);
        flush_in <= 1'b0;
    endtask

    task automatic check_idle();
        int i;
        cur_name  = "reset_idle";
        test_errs = 0;
        for (i = 0; i < 6; i++) begin
            @(negedge xclk);
            assert (!out_stb && !out_done) else begin
                $display("error: %s out_stb/out_done expected 0/0 got %0b/%0b",
                         cur_name, out_stb, out_done);
                test_errs++;
            end
        end
        if (test_errs != 0) failed++;
        $display("test %s: %0d errors", cur_name, test_errs);
    endtask

    task automatic run_test(input int t);
        int i;
        cur_name   = name_q[t];
        test_errs  = 0;
        frame_done = 1'b0;
        got_q.delete();
        build_expected(t);
        drive_frame(t);
        while (!frame_done) @(negedge xclk);  // cycle counter bounds this
        assert (got_q.size() == exp_q.size()) else begin
            $display("error: %s byte count expected %0d got %0d",
                     cur_name, exp_q.size(), got_q.size());
            test_errs++;
        end
        for (i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            assert (got_q[i] == exp_q[i]) else begin
                $display("error: %s byte %0d expected %02h got %02h",
                         cur_name, i, exp_q[i], got_q[i]);
                test_errs++;
            end
        end
        assert (done_bytes == exp_q.size()) else begin
            $display("error: %s frame_bytes expected %0d got %0d",
                     cur_name, exp_q.size(), done_bytes);
            test_errs++;
        end
        assert (want_q[t] < 0 || done_bytes == want_q[t]) else begin
            $display("error: %s frame_bytes expected %0d (file) got %0d",
                     cur_name, want_q[t], done_bytes);
            test_errs++;
        end
        if (test_errs != 0) failed++;
        $display("test %s: %0d bytes, %0d errors", cur_name, exp_q.size(), test_errs);
    endtask

    // output monitor, sampled away from the rising edge
    always @(negedge xclk) begin
        if (!rst && out_stb) begin
            mon_n = (out_done && out_bytes != 2'd0) ? int'(out_bytes) : 4;
            assert (out_done || out_bytes == 2'd0) else begin
                $display("error: %s mid-frame out_bytes expected 0 got %0d",
                         cur_name, out_bytes);
                test_errs++;
            end
            for (mon_k = 0; mon_k < mon_n; mon_k++) begin
                got_q.push_back(out_data[31 - 8*mon_k -: 8]);  // msb first
            end
            if (out_done) begin
                frame_done = 1'b1;
                done_bytes = int'(frame_bytes);
            end
        end
        assert (rst || out_stb || !out_done) else begin
            $display("%s: out_done came without an output word", cur_name);
            test_errs++;
        end
    end

    // run limit from the total code count
    always @(posedge xclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles in test %s, out_done never came",
                     cycle_cnt, cur_name);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        code     <= '0;
        code_len <= '0;
        code_stb <= 1'b0;
        flush_in <= 1'b0;
        seed      = 18230;
        cycle_cnt = 0;
        failed    = 0;
        load_errs = 0;
        load_stimulus();
        cycle_limit = 8 * code_q.size() + 100 * (name_q.size() + 1);
        while (rst !== 1'b0) @(posedge xclk);
        if (load_errs == 0) begin
            check_idle();
            for (int t = 0; t < name_q.size(); t++) run_test(t);
        end
        $display("tests %0d, passed %0d, failed %0d, stimulus errors %0d",
                 name_q.size() + 1, name_q.size() + 1 - failed, failed, load_errs);
        if (failed == 0 && load_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
// testbench clock and reset, 20 ns xclk with rst held for the first 2 cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
    output logic xclk,
    output logic rst
);
    initial begin
        xclk = 1'b0;
        forever #10 xclk = ~xclk;       // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge xclk);
        rst <= 1'b0;                    // released on the 2nd rising edge
    end

endmodule

`default_nettype wire

/* hw/byte_lane_fifo.sv */
// one byte lane of the escaper, small show-ahead fifo
`timescale 1ns/10ps
`default_nettype none

module byte_lane_fifo (
    input  wire                             xclk,
    input  wire                             rst,    // sync, active high
    input  wire                             we,     // push wdata
    input  wire                             re,     // pop, rdata moves on
    input  wire jpeg_tail_pkg::lane_entry_t wdata,
    output jpeg_tail_pkg::lane_entry_t      rdata,  // head entry, valid at nempty
    output logic                            nempty
);
    import jpeg_tail_pkg::*;

    lane_entry_t           mem [LANE_DEPTH];
    logic [LANE_PTR_W-1:0] wr_ptr;
    logic [LANE_PTR_W-1:0] rd_ptr;
    logic [LANE_PTR_W:0]   fill;   // entries held
    logic                  full;

    assign full   = fill == (LANE_PTR_W+1)'(LANE_DEPTH);
    assign nempty = fill != '0;
    assign rdata  = mem[rd_ptr];   // show-ahead

    always_ff @(posedge xclk) begin
        if (we) mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (we) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of 2
            if (re) rd_ptr <= rd_ptr + 1'b1;
            fill <= fill + (LANE_PTR_W+1)'(we) - (LANE_PTR_W+1)'(re);
        end
    end

    a_no_overflow: assert property (@(posedge xclk) disable iff (rst)
        we |-> !full || re) else $error("lane fifo overflow");
    a_no_underflow: assert property (@(posedge xclk) disable iff (rst)
        re |-> nempty) else $error("lane fifo underflow");

endmodule

`default_nettype wire

/* hw/ff_byte_escaper.sv */
// jpeg byte stuffer, puts 0x00 after every 0xff, 32-bit words in and out
`timescale 1ns/10ps
`default_nettype none

module ff_byte_escaper (
    input  wire                           xclk,
    input  wire                           rst,       // sync, active high
    input  wire jpeg_tail_pkg::word_t     din,       // msb aligned
    input  wire jpeg_tail_pkg::byte_cnt_t bytes_in,  // 0 means 4
    input  wire                           in_stb,    // din valid
    input  wire                           flush_in,  // after last in_stb
    output jpeg_tail_pkg::word_t          d_out,
    output jpeg_tail_pkg::byte_cnt_t      bytes_out, // valid at dv, 0 means 4
    output logic                          dv,        // d_out valid
    output logic                          flush_out  // after the final dv
);
    import jpeg_tail_pkg::*;

    logic [3:0]  wmask;          // lanes written, lane 3 is msb
    lane_entry_t lane_q [4];
    logic [3:0]  lane_nempty;
    logic [3:0]  lane_re;
    logic [1:0]  byte_ptr;       // next byte position, 0 = lane 3
    logic        cry_ff;         // last byte sent was 0xff, zero still owed
    logic [7:0]  rot_data [4];   // lanes in stream order from byte_ptr
    logic [3:0]  rot_ne;
    logic [3:0]  rot_ff;
    logic [7:0]  sel_byte [4];   // output slots, 0 is msb
    logic [3:0]  slot_rdy;
    logic [3:0]  take;           // rotated sources consumed
    logic [3:0]  re_take;        // take mapped back to lanes
    logic [2:0]  src;            // bytes consumed by this word
    logic [2:0]  n_valid;        // leading ready slots
    logic        pend_zero;
    logic        run;
    logic        rdy;            // full output word available
    logic        cry_nxt;
    logic        flush_pend;     // flush seen, full words still draining
    logic        drain;          // read out the rest, partial word
    logic        flush_d;

    function automatic logic [1:0] lane_of(input logic [1:0] ptr, input logic [1:0] pos);
        return 2'd3 - ptr - pos;
    endfunction

    always_comb begin
        case (bytes_in)
            2'd1:    wmask = 4'b1000;
            2'd2:    wmask = 4'b1100;
            2'd3:    wmask = 4'b1110;
            default: wmask = 4'b1111;
        endcase
    end

    for (genvar i = 0; i < 4; i++) begin : g_lane
        byte_lane_fifo lane_inst (
            .xclk   (xclk),
            .rst    (rst),
            .we     (in_stb && wmask[i]),
            .re     (lane_re[i]),
            .wdata  ({&din[8*i +: 8], din[8*i +: 8]}), // flag 0xff on the way in
            .rdata  (lane_q[i]),
            .nempty (lane_nempty[i])
        );
    end

    // barrel, stream order starting at byte_ptr
    always_comb begin
        for (int j = 0; j < 4; j++) begin
            rot_data[j] = lane_q[lane_of(byte_ptr, 2'(j))].data;
            rot_ne[j]   = lane_nempty[lane_of(byte_ptr, 2'(j))];
            rot_ff[j]   = lane_q[lane_of(byte_ptr, 2'(j))].is_ff & rot_ne[j]; // empty lane no ff
        end
    end

    // fill the four slots, an owed zero takes a slot before the next byte
    always_comb begin
        pend_zero = cry_ff;
        src       = 3'd0;
        run       = 1'b1;
        n_valid   = 3'd0;
        take      = 4'b0;
        for (int k = 0; k < 4; k++) begin
            if (pend_zero) begin
                sel_byte[k] = ESC_BYTE;
                slot_rdy[k] = 1'b1;
                pend_zero   = 1'b0;
            end else begin
                sel_byte[k]       = rot_data[src[1:0]];
                slot_rdy[k]       = rot_ne[src[1:0]];
                pend_zero         = rot_ff[src[1:0]];
                take[src[1:0]]    = 1'b1;
                src               = src + 3'd1;
            end
            run = run & slot_rdy[k];
            if (run) n_valid = n_valid + 3'd1;
        end
        cry_nxt = pend_zero; // 0xff in the last slot, zero goes to next word
        rdy     = run;
    end

    always_comb begin
        re_take = 4'b0;
        for (int j = 0; j < 4; j++) begin
            re_take[lane_of(byte_ptr, 2'(j))] = take[j];
        end
        lane_re = drain ? lane_nempty : (rdy ? re_take : 4'b0); // drain empties all
    end

    always_ff @(posedge xclk) begin
        if (rst || drain) begin
            cry_ff   <= 1'b0;
            byte_ptr <= 2'd0; // next frame starts at lane 3
        end else if (rdy) begin
            cry_ff   <= cry_nxt;
            byte_ptr <= byte_ptr + src[1:0]; // 4 bytes wraps to same lane
        end
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            dv         <= 1'b0;
            flush_pend <= 1'b0;
            drain      <= 1'b0;
            flush_d    <= 1'b0;
            flush_out  <= 1'b0;
        end else begin
            dv <= rdy || (drain && n_valid != 3'd0);
            if (flush_in)               flush_pend <= 1'b1;
            else if (flush_pend && !rdy) flush_pend <= 1'b0;
            drain     <= flush_pend && !rdy; // no full word left
            flush_d   <= drain;
            flush_out <= flush_d;            // one cycle behind the tail word
        end
    end

    always_ff @(posedge xclk) begin
        if (rdy || drain) begin
            for (int k = 0; k < 4; k++) begin
                d_out[31 - 8*k -: 8] <= sel_byte[k];
            end
            bytes_out <= rdy ? 2'd0 : n_valid[1:0];
        end
    end

    // the drain would drop a word arriving behind the flush
    a_no_word_in_flush: assert property (@(posedge xclk) disable iff (rst)
        (flush_pend || drain) |-> !in_stb)
        else $error("escaper input word after flush");

endmodule

`default_nettype wire

/* hw/huff_bit_packer.sv */
// huffman bit packer, variable length codes into msb aligned 32-bit words
`timescale 1ns/10ps
`default_nettype none

module huff_bit_packer (
    input  wire                           xclk,     // stream clock
    input  wire                           rst,      // sync, active high
    input  wire jpeg_tail_pkg::code_t     code,     // right aligned code bits
    input  wire jpeg_tail_pkg::code_len_t code_len, // 0..16
    input  wire                           code_stb, // code/code_len valid
    input  wire                           flush_in, // after last code of frame
    output jpeg_tail_pkg::word_t          pk_data,  // msb aligned word
    output jpeg_tail_pkg::byte_cnt_t      pk_bytes, // 0 means 4
    output logic                          pk_stb,   // pk_data valid
    output logic                          pk_flush  // one cycle after last pk_stb
);
    import jpeg_tail_pkg::*;

    logic [ACC_W-1:0] acc;       // held bits, filled from the top down
    logic [5:0]       bit_cnt;   // bits held, below 32 between codes
    logic [ACC_W-1:0] code_bits; // new code moved to the top
    logic [ACC_W-1:0] acc_nxt;   // acc with the new code below old bits
    logic [ACC_W-1:0] acc_pad;   // acc with ones below the held bits
    logic [5:0]       cnt_nxt;
    logic [2:0]       pad_bytes; // bytes in the padded tail, 0..4
    logic             word_full; // 32 bits or more after this code
    logic             flush_q;   // flush delayed to follow the tail word

    always_comb begin
        // drop bits above code_len, then msb align
        code_bits = {code & ((16'h1 << code_len) - 16'h1), {(ACC_W-16){1'b0}}};
        code_bits = code_bits << (5'd16 - code_len);
        acc_nxt   = acc | (code_bits >> bit_cnt);
        cnt_nxt   = bit_cnt + {1'b0, code_len};
        word_full = cnt_nxt >= 6'd32;
        acc_pad   = acc | ({ACC_W{1'b1}} >> bit_cnt); // jpeg pads with ones
        pad_bytes = 3'((bit_cnt + 6'd7) >> 3);         // round up to bytes
    end

    // control and accumulator
    always_ff @(posedge xclk) begin
        if (rst) begin
            acc      <= '0;
            bit_cnt  <= '0;
            pk_stb   <= 1'b0;
            flush_q  <= 1'b0;
            pk_flush <= 1'b0;
        end else begin
            flush_q  <= flush_in;
            pk_flush <= flush_q;
            pk_stb   <= 1'b0;
            if (flush_in) begin
                pk_stb  <= bit_cnt != 6'd0; // nothing left, no tail word
                acc     <= '0;
                bit_cnt <= '0;
            end else if (code_stb) begin
                if (word_full) begin
                    pk_stb  <= 1'b1;
                    acc     <= acc_nxt << 32; // keep the overflow bits
                    bit_cnt <= cnt_nxt - 6'd32;
                end else begin
                    acc     <= acc_nxt;
                    bit_cnt <= cnt_nxt;
                end
            end
        end
    end

    // output word
    always_ff @(posedge xclk) begin
        if (flush_in) begin
            pk_data  <= acc_pad[ACC_W-1 -: 32];
            pk_bytes <= pad_bytes[1:0]; // 4 wraps to 0
        end else if (code_stb && word_full) begin
            pk_data  <= acc_nxt[ACC_W-1 -: 32];
            pk_bytes <= 2'd0;           // mid-frame words are full
        end
    end

    a_code_len: assert property (@(posedge xclk) disable iff (rst)
        code_stb |-> code_len <= 5'd16)
        else $error("code_len above 16");

endmodule

`default_nettype wire

/* hw/jpeg_entropy_tail.sv */
// entropy coder tail, bit packer to byte stuffer to output packer
`timescale 1ns/10ps
`default_nettype none

module jpeg_entropy_tail (
    input  wire                           xclk,
    input  wire                           rst,         // sync, active high
    input  wire jpeg_tail_pkg::code_t     code,
    input  wire jpeg_tail_pkg::code_len_t code_len,
    input  wire                           code_stb,
    input  wire                           flush_in,    // after last code
    output jpeg_tail_pkg::word_t          out_data,
    output jpeg_tail_pkg::byte_cnt_t      out_bytes,
    output logic                          out_stb,
    output logic                          out_done,
    output jpeg_tail_pkg::frame_cnt_t     frame_bytes
);
    import jpeg_tail_pkg::*;

    word_t     pk_data;   // packer to escaper
    byte_cnt_t pk_bytes;
    logic      pk_stb;
    logic      pk_flush;
    word_t     esc_data;  // escaper to tail packer
    byte_cnt_t esc_bytes;
    logic      esc_dv;
    logic      esc_flush;

    huff_bit_packer huff_bit_packer_inst (
        .xclk     (xclk),     .rst      (rst),
        .code     (code),     .code_len (code_len),
        .code_stb (code_stb), .flush_in (flush_in),
        .pk_data  (pk_data),  .pk_bytes (pk_bytes),
        .pk_stb   (pk_stb),   .pk_flush (pk_flush)
    );

    ff_byte_escaper ff_byte_escaper_inst (
        .xclk     (xclk),     .rst       (rst),
        .din      (pk_data),  .bytes_in  (pk_bytes),
        .in_stb   (pk_stb),   .flush_in  (pk_flush),
        .d_out    (esc_data), .bytes_out (esc_bytes),
        .dv       (esc_dv),   .flush_out (esc_flush)
    );

    jpeg_tail_packer jpeg_tail_packer_inst (
        .xclk     (xclk),     .rst       (rst),
        .din      (esc_data), .bytes_in  (esc_bytes),
        .dv       (esc_dv),   .flush_in  (esc_flush),
        .out_data (out_data), .out_bytes (out_bytes),
        .out_stb  (out_stb),  .out_done  (out_done),
        .frame_bytes (frame_bytes)
    );

endmodule

`default_nettype wire

/* hw/jpeg_tail_packer.sv */
// output packer, passes full words, appends ff d9 and counts frame bytes
`timescale 1ns/10ps
`default_nettype none

module jpeg_tail_packer (
    input  wire                           xclk,
    input  wire                           rst,         // sync, active high
    input  wire jpeg_tail_pkg::word_t     din,         // escaped word
    input  wire jpeg_tail_pkg::byte_cnt_t bytes_in,    // nonzero only on tail word
    input  wire                           dv,
    input  wire                           flush_in,    // after last dv
    output jpeg_tail_pkg::word_t          out_data,
    output jpeg_tail_pkg::byte_cnt_t      out_bytes,   // nonzero only on last word
    output logic                          out_stb,
    output logic                          out_done,    // with the last word
    output jpeg_tail_pkg::frame_cnt_t     frame_bytes  // valid at out_done
);
    import jpeg_tail_pkg::*;

    frame_cnt_t  byte_cnt;   // bytes sent so far this frame
    word_t       hold_data;  // tail bytes, later the second eoi word
    logic [1:0]  hold_n;     // tail bytes held, 0..3
    logic        eoi_pend;   // second word still to go
    logic [31:0] keep_mask;
    logic [63:0] merged;     // tail bytes then ff d9
    logic [2:0]  tail_n;     // bytes in merged, 2..5

    always_comb begin
        keep_mask = ~(32'hFFFF_FFFF >> {hold_n, 3'b000});
        merged    = {hold_data & keep_mask, 32'h0} | ({EOI_MARKER, 48'h0} >> {hold_n, 3'b000});
        tail_n    = {1'b0, hold_n} + 3'd2;
    end

    always_ff @(posedge xclk) begin
        if (rst) begin
            out_stb  <= 1'b0;
            out_done <= 1'b0;
            eoi_pend <= 1'b0;
            hold_n   <= 2'd0;
            byte_cnt <= '0;
        end else begin
            out_stb  <= 1'b0;
            out_done <= 1'b0;
            eoi_pend <= 1'b0;
            if (eoi_pend) begin
                out_stb  <= 1'b1;
                out_done <= 1'b1;
            end else if (flush_in) begin
                out_stb  <= 1'b1;
                out_done <= tail_n <= 3'd4;   // fits one word
                eoi_pend <= tail_n > 3'd4;    // d9 spills over
                hold_n   <= 2'd0;
                byte_cnt <= '0;
            end else if (dv) begin
                if (bytes_in == 2'd0) begin
                    out_stb  <= 1'b1;
                    byte_cnt <= byte_cnt + frame_cnt_t'(4);
                end else begin
                    hold_n <= bytes_in;       // short word waits for flush
                end
            end
        end
    end

    always_ff @(posedge xclk) begin
        if (eoi_pend) begin
            out_data  <= hold_data;
            out_bytes <= 2'd1;                // lone d9
        end else if (flush_in) begin
            out_data    <= merged[63:32];
            out_bytes   <= (tail_n > 3'd4) ? 2'd0 : tail_n[1:0];
            hold_data   <= merged[31:0];
            frame_bytes <= byte_cnt + frame_cnt_t'(tail_n);
        end else if (dv) begin
            if (bytes_in == 2'd0) begin
                out_data  <= din;
                out_bytes <= 2'd0;
            end else begin
                hold_data <= din;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/jpeg_tail_pkg.sv */
// jpeg entropy tail, shared stream types and constants
`default_nettype none

package jpeg_tail_pkg;

    typedef logic [31:0] word_t;      // stream word, msb aligned
    typedef logic [1:0]  byte_cnt_t;  // valid bytes from msb, 0 means 4
    typedef logic [15:0] code_t;      // huffman code, right aligned
    typedef logic [4:0]  code_len_t;  // code length 0..16
    typedef logic [23:0] frame_cnt_t; // bytes per frame

    typedef struct packed {
        logic       is_ff;  // data byte is 0xff
        logic [7:0] data;
    } lane_entry_t;

    localparam int          ACC_W      = 48;                 // packer accumulator bits
    localparam int          LANE_DEPTH = 4;                  // entries per lane fifo
    localparam int          LANE_PTR_W = $clog2(LANE_DEPTH);
    localparam logic [7:0]  ESC_BYTE   = 8'h00;              // stuffed after each 0xff
    localparam logic [15:0] EOI_MARKER = 16'hFFD9;           // end of image

endpackage

`default_nettype wire

/* project.f */
hw/jpeg_tail_pkg.sv
hw/huff_bit_packer.sv
hw/byte_lane_fifo.sv
hw/ff_byte_escaper.sv
hw/jpeg_tail_packer.sv
hw/jpeg_entropy_tail.sv
dv/tb_clk_gen.sv
dv/jpeg_entropy_tail_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the jpeg entropy tail testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module jpeg_entropy_tail_tb \
    -f project.f \
    -o jpeg_entropy_tail_sim

./obj_dir/jpeg_entropy_tail_sim | tee sim.log

# the testbench prints its verdict on a line of its own
if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation passed, see sim.log"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
